/* include/mipsPipe_params.svh */
`ifndef MIPS_PIPE_PARAMS_SVH
`define MIPS_PIPE_PARAMS_SVH

// word, PC and ALU width
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5

`define DMEM_WORDS     64 // data RAM depth in words

// fetch sequencing
`define RESET_PC       32'h0000_0000
`define PC_STEP        4 // bytes per instruction

// add $0,$0,$0, also the decode-stage bubble
`define NOP_WORD       32'h0000_0020

`endif

/* src/mipsPipePkg.sv */
package mipsPipePkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opRtype = 6'b000000,
        opBeq   = 6'b000100,
        opAddi  = 6'b001000,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    // R-type funct, instr[5:0]
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } functT;

    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluCtrlT;

    // execute operand source
    typedef enum logic [1:0] {
        fromRegFile   = 2'b00,
        fromWriteback = 2'b01,
        fromMemory    = 2'b10
    } forwardSelT;

endpackage

/* src/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder (
    input  mipsPipePkg::opcodeT  opD,
    input  mipsPipePkg::functT   functD,
    output logic                 regWriteD,
    output logic                 memToRegD,
    output logic                 memWriteD,
    output logic                 aluSrcD,
    output logic                 regDstD,
    output logic                 branchD,
    output mipsPipePkg::aluCtrlT aluCtrlD
);
    typedef enum logic [1:0] {
        classAdd,   // lw, sw, addi
        classSub,   // beq compare
        classFunct  // R-type, funct decides
    } aluClassT;

    aluClassT aluClass;

    // **************************************************
    // main decoder
    // **************************************************
    always_comb begin
        regWriteD = 1'b0;
        memToRegD = 1'b0;
        memWriteD = 1'b0;
        aluSrcD   = 1'b0;
        regDstD   = 1'b0;
        branchD   = 1'b0;
        aluClass  = classAdd;
        case (opD)
            mipsPipePkg::opRtype: begin
                regWriteD = 1'b1;
                regDstD   = 1'b1; // rd is the destination
                aluClass  = classFunct;
            end
            mipsPipePkg::opLw: begin
                regWriteD = 1'b1;
                memToRegD = 1'b1;
                aluSrcD   = 1'b1;
            end
            mipsPipePkg::opSw: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            mipsPipePkg::opBeq: begin
                branchD  = 1'b1;
                aluClass = classSub; // zero flag means equal
            end
            mipsPipePkg::opAddi: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            default: regWriteD = 1'b0; // unknown opcode acts as a bubble
        endcase
    end

    // **************************************************
    // ALU decoder
    // **************************************************
    always_comb begin
        case (aluClass)
            classSub: aluCtrlD = mipsPipePkg::aluSub;
            classFunct: begin
                case (functD)
                    mipsPipePkg::fnSub: aluCtrlD = mipsPipePkg::aluSub;
                    mipsPipePkg::fnAnd: aluCtrlD = mipsPipePkg::aluAnd;
                    mipsPipePkg::fnOr:  aluCtrlD = mipsPipePkg::aluOr;
                    mipsPipePkg::fnSlt: aluCtrlD = mipsPipePkg::aluSlt;
                    default:            aluCtrlD = mipsPipePkg::aluAdd;
                endcase
            end
            default: aluCtrlD = mipsPipePkg::aluAdd;
        endcase
    end

endmodule

/* src/hazardUnit.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module hazardUnit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`REG_ADDR_WIDTH-1:0]    rsD, rtD, rsE, rtE,
    input  logic [`REG_ADDR_WIDTH-1:0]    writeRegM, writeRegW,
    input  logic                          regWriteM, regWriteW,
    input  logic                          memToRegE,
    input  logic                          pcSrcM,
    output mipsPipePkg::forwardSelT       forwardAE, forwardBE,
    output logic                          stallF, stallD, flushD, flushE
);
    logic lwStall;

    // newest producer wins, $0 is never forwarded
    function automatic mipsPipePkg::forwardSelT pickSource(
        input logic [`REG_ADDR_WIDTH-1:0] srcReg
    );
        mipsPipePkg::forwardSelT sel;
        sel = mipsPipePkg::fromRegFile;
        if (srcReg != '0) begin
            if (regWriteM && srcReg == writeRegM) begin
                sel = mipsPipePkg::fromMemory;
            end else if (regWriteW && srcReg == writeRegW) begin
                sel = mipsPipePkg::fromWriteback;
            end
        end
        return sel;
    endfunction

    always_comb begin
        forwardAE = pickSource(rsE);
        forwardBE = pickSource(rtE);
    end

    // load in execute feeding the instruction in decode
    assign lwStall = memToRegE && (rtE != '0) && (rtE == rsD || rtE == rtD);

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = pcSrcM;           // wrong-path fetch
    assign flushE = lwStall | pcSrcM; // bubble or wrong-path decode

    // the bubble leaves memToRegE low, so a load-use stall cannot repeat
    stallOneCycle: assert property (@(posedge clk) disable iff (reset)
        stallD |=> !stallD);

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module regFile (
    input  logic                         clk,
    input  logic                         writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0]   readAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0]   readAddr2,
    input  logic [`REG_ADDR_WIDTH-1:0]   writeAddr,
    input  logic [`DATA_WIDTH-1:0]       writeData,
    output logic [`DATA_WIDTH-1:0]       readData1,
    output logic [`DATA_WIDTH-1:0]       readData2
);
    logic [`DATA_WIDTH-1:0] regs [2**(`REG_ADDR_WIDTH)];

    // written mid-cycle so decode reads the new value
    always_ff @(negedge clk) begin
        if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1]; // $0 reads zero
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* src/dataMem.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module dataMem (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     writeEnable,
    input  logic [`DATA_WIDTH-1:0]   addr,
    input  logic [`DATA_WIDTH-1:0]   writeData,
    output logic [`DATA_WIDTH-1:0]   readData
);
    localparam int indexWidth = $clog2(`DMEM_WORDS);

    logic [`DATA_WIDTH-1:0] mem [`DMEM_WORDS];
    logic [indexWidth-1:0]  wordIndex;

    assign wordIndex = addr[indexWidth+1:2]; // byte address to word
    assign readData  = mem[wordIndex];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[wordIndex] <= writeData;
        end
    end

    storeAddrOk: assert property (@(posedge clk) disable iff (reset)
        writeEnable |-> (addr[1:0] == 2'b00 && addr < (`DMEM_WORDS * 4)));

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module aluUnit (
    input  logic [`DATA_WIDTH-1:0]   srcA,
    input  logic [`DATA_WIDTH-1:0]   srcB,
    input  mipsPipePkg::aluCtrlT     aluCtrl,
    output logic [`DATA_WIDTH-1:0]   result,
    output logic                     zero
);
    always_comb begin
        case (aluCtrl)
            mipsPipePkg::aluAnd: result = srcA & srcB;
            mipsPipePkg::aluOr:  result = srcA | srcB;
            mipsPipePkg::aluAdd: result = srcA + srcB;
            mipsPipePkg::aluSub: result = srcA - srcB;
            mipsPipePkg::aluSlt: begin
                // unsigned compare
                result = {{(`DATA_WIDTH-1){1'b0}}, (srcA < srcB)};
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* src/pipelineDatapath.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module pipelineDatapath (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`DATA_WIDTH-1:0]       instrF,
    output logic [`DATA_WIDTH-1:0]       pcF,
    input  logic                         regWriteD, memToRegD, memWriteD,
    input  logic                         aluSrcD, regDstD, branchD,
    input  mipsPipePkg::aluCtrlT         aluCtrlD,
    input  mipsPipePkg::forwardSelT      forwardAE, forwardBE,
    input  logic                         stallF, stallD, flushD, flushE,
    output mipsPipePkg::opcodeT          opD,
    output mipsPipePkg::functT           functD,
    output logic [`REG_ADDR_WIDTH-1:0]   rsD, rtD, rsE, rtE,
    output logic [`REG_ADDR_WIDTH-1:0]   writeRegM, writeRegW,
    output logic                         regWriteM, regWriteW, memToRegE, pcSrcM,
    input  logic [`DATA_WIDTH-1:0]       readData1, readData2,
    output logic [`DATA_WIDTH-1:0]       resultW,
    output logic [`DATA_WIDTH-1:0]       aluOutM, writeDataM,
    output logic                         memWriteM,
    input  logic [`DATA_WIDTH-1:0]       readDataM
);
    logic [`DATA_WIDTH-1:0]     pcPlus4F, instrD, pcPlus4D, signImmD;
    logic [`REG_ADDR_WIDTH-1:0] rdD, rdE, writeRegE;
    logic                       regWriteE, memWriteE, aluSrcE, regDstE, branchE, zeroE;
    mipsPipePkg::aluCtrlT       aluCtrlE;
    logic [`DATA_WIDTH-1:0]     rd1E, rd2E, signImmE, pcPlus4E;
    logic [`DATA_WIDTH-1:0]     srcAE, srcBE, writeDataE, aluOutE, pcBranchE;
    logic                       memToRegM, branchM, zeroM;
    logic [`DATA_WIDTH-1:0]     pcBranchM;
    logic                       memToRegW;
    logic [`DATA_WIDTH-1:0]     readDataW, aluOutW;

    // **************************************************
    // fetch and decode
    // **************************************************
    assign pcPlus4F = pcF + `PC_STEP;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pcF <= `RESET_PC;
        end else if (pcSrcM) begin
            pcF <= pcBranchM; // taken beq overrides a stall
        end else if (!stallF) begin
            pcF <= pcPlus4F;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrD   <= `NOP_WORD;
            pcPlus4D <= '0;
        end else if (flushD) begin
            instrD   <= `NOP_WORD;
            pcPlus4D <= '0;
        end else if (!stallD) begin
            instrD   <= instrF;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign opD      = mipsPipePkg::opcodeT'(instrD[31:26]);
    assign functD   = mipsPipePkg::functT'(instrD[5:0]);
    assign rsD      = instrD[25:21];
    assign rtD      = instrD[20:16];
    assign rdD      = instrD[15:11];
    assign signImmD = {{(`DATA_WIDTH-16){instrD[15]}}, instrD[15:0]};

    // **************************************************
    // pipeline registers, decode to writeback
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            memWriteM <= 1'b0;
            branchM   <= 1'b0;
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            regWriteE <= regWriteD & ~flushE; // bubble into execute
            memToRegE <= memToRegD & ~flushE;
            memWriteE <= memWriteD & ~flushE;
            branchE   <= branchD & ~flushE;
            // wrong-path instruction in execute dies on its way to memory
            regWriteM <= regWriteE & ~pcSrcM;
            memToRegM <= memToRegE & ~pcSrcM;
            memWriteM <= memWriteE & ~pcSrcM;
            branchM   <= branchE & ~pcSrcM;
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
        end
    end

    // operands and addresses, qualified by the enables above
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluSrcE    <= 1'b0;
            regDstE    <= 1'b0;
            aluCtrlE   <= mipsPipePkg::aluAnd;
            rd1E       <= '0;
            rd2E       <= '0;
            rsE        <= '0;
            rtE        <= '0;
            rdE        <= '0;
            signImmE   <= '0;
            pcPlus4E   <= '0;
            zeroM      <= 1'b0;
            aluOutM    <= '0;
            writeDataM <= '0;
            writeRegM  <= '0;
            pcBranchM  <= '0;
            readDataW  <= '0;
            aluOutW    <= '0;
            writeRegW  <= '0;
        end else begin
            aluSrcE    <= aluSrcD;
            regDstE    <= regDstD;
            aluCtrlE   <= aluCtrlD;
            rd1E       <= readData1;
            rd2E       <= readData2;
            rsE        <= rsD;
            rtE        <= rtD;
            rdE        <= rdD;
            signImmE   <= signImmD;
            pcPlus4E   <= pcPlus4D;
            zeroM      <= zeroE;
            aluOutM    <= aluOutE;
            writeDataM <= writeDataE;
            writeRegM  <= writeRegE;
            pcBranchM  <= pcBranchE;
            readDataW  <= readDataM;
            aluOutW    <= aluOutM;
            writeRegW  <= writeRegM;
        end
    end

    // **************************************************
    // execute
    // **************************************************
    always_comb begin
        case (forwardAE)
            mipsPipePkg::fromMemory:    srcAE = aluOutM;
            mipsPipePkg::fromWriteback: srcAE = resultW;
            default:                    srcAE = rd1E;
        endcase
        case (forwardBE)
            mipsPipePkg::fromMemory:    writeDataE = aluOutM;
            mipsPipePkg::fromWriteback: writeDataE = resultW;
            default:                    writeDataE = rd2E;
        endcase
    end

    assign srcBE     = aluSrcE ? signImmE : writeDataE;
    assign writeRegE = regDstE ? rdE : rtE;
    assign pcBranchE = pcPlus4E + (signImmE << 2); // word offset from PC+4

    aluUnit aluInst (
        .srcA    (srcAE),
        .srcB    (srcBE),
        .aluCtrl (aluCtrlE),
        .result  (aluOutE),
        .zero    (zeroE)
    );

    // beq resolves here
    assign pcSrcM  = branchM & zeroM;
    assign resultW = memToRegW ? readDataW : aluOutW;

    // decode only ever holds opcodes the decoder implements
    opKnown: assert property (@(posedge clk) disable iff (reset)
        opD inside {mipsPipePkg::opRtype, mipsPipePkg::opLw, mipsPipePkg::opSw,
                    mipsPipePkg::opBeq, mipsPipePkg::opAddi});

endmodule

/* src/mipsPipe.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module mipsPipe (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`DATA_WIDTH-1:0]   instrF,
    output logic [`DATA_WIDTH-1:0]   pcF,
    output logic                     memWrite,
    output logic [`DATA_WIDTH-1:0]   dataAdr,
    output logic [`DATA_WIDTH-1:0]   writeData
);
    mipsPipePkg::opcodeT        opD;
    mipsPipePkg::functT         functD;
    mipsPipePkg::aluCtrlT       aluCtrlD;
    mipsPipePkg::forwardSelT    forwardAE, forwardBE;
    logic                       regWriteD, memToRegD, memWriteD, aluSrcD, regDstD, branchD;
    logic                       stallF, stallD, flushD, flushE;
    logic [`REG_ADDR_WIDTH-1:0] rsD, rtD, rsE, rtE, writeRegM, writeRegW;
    logic                       regWriteM, regWriteW, memToRegE, pcSrcM;
    logic [`DATA_WIDTH-1:0]     readData1, readData2, resultW, readDataM;

    controlDecoder decoderInst (.*);

    hazardUnit hazardInst (.*);

    // memory stage drives the store strobe, address and data
    pipelineDatapath datapathInst (
        .aluOutM    (dataAdr),
        .writeDataM (writeData),
        .memWriteM  (memWrite),
        .*
    );

    regFile regFileInst (
        .clk         (clk),
        .writeEnable (regWriteW),
        .readAddr1   (rsD),
        .readAddr2   (rtD),
        .writeAddr   (writeRegW),
        .writeData   (resultW),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    dataMem dataMemInst (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (memWrite),
        .addr        (dataAdr),
        .writeData   (writeData),
        .readData    (readDataM)
    );

endmodule

/* tb/mipsPipe_tb.sv */
`timescale 1ns/1ps
`include "mipsPipe_params.svh"

module mipsPipe_tb;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 4;
    localparam int romAw       = 6;
    localparam int romWords    = 2**romAw;
    localparam int dataWords   = 256; // three words per record

    logic                   clk;
    logic                   reset;
    logic [`DATA_WIDTH-1:0] instrF;
    logic [`DATA_WIDTH-1:0] pcF;
    logic                   memWrite;
    logic [`DATA_WIDTH-1:0] dataAdr;
    logic [`DATA_WIDTH-1:0] writeData;

    logic [31:0]            testData [dataWords];
    logic [`DATA_WIDTH-1:0] rom [romWords];
    logic [`DATA_WIDTH-1:0] expAddrQ [$];
    logic [`DATA_WIDTH-1:0] expDataQ [$];
    int                     programWords;
    int                     watchdogCycles;
    logic                   loaded = 1'b0;

    mipsPipe mipsPipe_inst (
        .clk       (clk),
        .reset     (reset),
        .instrF    (instrF),
        .pcF       (pcF),
        .memWrite  (memWrite),
        .dataAdr   (dataAdr),
        .writeData (writeData)
    );

    // instruction ROM, unprogrammed words read as nop
    assign instrF = (pcF[`DATA_WIDTH-1:2] < romWords) ? rom[pcF[romAw+1:2]] : `NOP_WORD;

    // **************************************************
    // helpers
    // **************************************************
    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compareWord(input string name,
                               input logic [`DATA_WIDTH-1:0] actual,
                               input logic [`DATA_WIDTH-1:0] expected);
        assert (actual === expected) else begin
            stopWithError($sformatf("mismatch at %0t ns: %s expected %h, got %h",
                                    $time, name, expected, actual));
        end
    endtask

    task automatic loadTestData();
        int i;
        for (i = 0; i < dataWords; i++) begin
            testData[i] = '0;
        end
        for (i = 0; i < romWords; i++) begin
            rom[i] = `NOP_WORD;
        end
        $readmemh("tb/mipsPipe_testdata.hex", testData);
        programWords = 0;
        i = 0;
        // records of kind, address, data until a zero kind
        while (i + 2 < dataWords && testData[i] != 0) begin
            case (testData[i])
                32'd1: begin
                    assert (testData[i+1] < romWords) else begin
                        stopWithError("a program word address lies outside the ROM model");
                    end
                    rom[testData[i+1][romAw-1:0]] = testData[i+2];
                    programWords++;
                end
                32'd2: begin
                    expAddrQ.push_back(testData[i+1]);
                    expDataQ.push_back(testData[i+2]);
                end
                default: stopWithError("the test data holds a record of unknown kind");
            endcase
            i += 3;
        end
        assert (programWords > 0 && expAddrQ.size() > 0) else begin
            stopWithError("the test data file holds no program or no expected stores");
        end
    endtask

    // **************************************************
    // clock, reset and stimulus
    // **************************************************
    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        loadTestData();
        watchdogCycles = 20 * programWords + 100; // per program word plus slack
        loaded = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

    // pipeline held at the reset PC with no store
    always @(negedge clk) begin
        if (reset === 1'b1) begin
            compareWord("pcF", pcF, `RESET_PC);
            compareWord("memWrite", 32'(memWrite), 32'd0);
        end
    end

    // first fetches after reset step by one word
    initial begin : fetchOrder
        int k;
        @(negedge reset);
        for (k = 0; k < 3; k++) begin
            @(negedge clk);
            compareWord("pcF", pcF, 32'(`RESET_PC + k * `PC_STEP));
            if (k == 0) begin
                compareWord("memWrite", 32'(memWrite), 32'd0);
            end
        end
    end

    // every store strobe must match the next expected store
    always @(posedge clk) begin : storeCheck
        logic [`DATA_WIDTH-1:0] expAddr;
        logic [`DATA_WIDTH-1:0] expData;
        if (memWrite === 1'b1) begin
            assert (expAddrQ.size() > 0) else begin
                stopWithError($sformatf("unexpected store at %0t ns to address %h",
                                        $time, dataAdr));
            end
            expAddr = expAddrQ.pop_front();
            expData = expDataQ.pop_front();
            compareWord("dataAdr", dataAdr, expAddr);
            compareWord("writeData", writeData, expData);
        end
    end

    // **************************************************
    // watchdog and end of run
    // **************************************************
    initial begin
        wait (loaded === 1'b1);
        repeat (watchdogCycles) @(negedge clk); // self-loop must stay silent till here
        if (expAddrQ.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stopWithError($sformatf("timeout, %0d expected stores never appeared",
                                    expAddrQ.size()));
        end
    end

endmodule

/* tb/mipsPipe_testdata.hex */
// columns: kind address data, all hex
// kind 1 = program word (word address, instruction), kind 2 = expected store (byte address, data)
00000001 00000000 20020005 // addi $2, $0, 5
00000001 00000001 2003000C // addi $3, $0, 12
00000001 00000002 2067FFF7 // addi $7, $3, -9      forward from memory
00000001 00000003 AC070000 // sw   $7, 0($0)       store data forwarded
00000001 00000004 00E22025 // or   $4, $7, $2      forward from writeback
00000001 00000005 AC040004 // sw   $4, 4($0)
00000001 00000006 00642824 // and  $5, $3, $4
00000001 00000007 00A43020 // add  $6, $5, $4
00000001 00000008 AC060008 // sw   $6, 8($0)
00000001 00000009 00C24022 // sub  $8, $6, $2
00000001 0000000A AC08000C // sw   $8, 12($0)
00000001 0000000B 00E2482A // slt  $9, $7, $2
00000001 0000000C 200AFFFD // addi $10, $0, -3
00000001 0000000D 0142582A // slt  $11, $10, $2    unsigned compare
00000001 0000000E AC090010 // sw   $9, 16($0)
00000001 0000000F AC0B0014 // sw   $11, 20($0)
00000001 00000010 AC0A0018 // sw   $10, 24($0)
00000001 00000011 AC05001C // sw   $5, 28($0)
00000001 00000012 8C0C0008 // lw   $12, 8($0)
00000001 00000013 01826820 // add  $13, $12, $2    load-use stall
00000001 00000014 AC0D0020 // sw   $13, 32($0)
00000001 00000015 8C0E0004 // lw   $14, 4($0)
00000001 00000016 AC0E0024 // sw   $14, 36($0)     load-use on store data
00000001 00000017 10430005 // beq  $2, $3, 5       not taken
00000001 00000018 200F0021 // addi $15, $0, 33
00000001 00000019 10840003 // beq  $4, $4, 3       taken to word 29
00000001 0000001A 200F0063 // addi $15, $0, 99     wrong path
00000001 0000001B AC020028 // sw   $2, 40($0)      wrong path
00000001 0000001C 21EF0001 // addi $15, $15, 1     wrong path
00000001 0000001D AC0F002C // sw   $15, 44($0)
00000001 0000001E 1000FFFF // beq  $0, $0, -1      self-loop
00000002 00000000 00000003
00000002 00000004 00000007
00000002 00000008 0000000B
00000002 0000000C 00000006
00000002 00000010 00000001
00000002 00000014 00000000
00000002 00000018 FFFFFFFD
00000002 0000001C 00000004
00000002 00000020 00000010
00000002 00000024 00000007
00000002 0000002C 00000021

/* mipsPipe.f */
+incdir+include
src/mipsPipePkg.sv
src/controlDecoder.sv
src/hazardUnit.sv
src/regFile.sv
src/dataMem.sv
src/aluUnit.sv
src/pipelineDatapath.sv
src/mipsPipe.sv
tb/mipsPipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the mipsPipe testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module mipsPipe_tb -f mipsPipe.f

status=0
./obj_dir/VmipsPipe_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation run failed, see sim.log"
    exit 1
fi
echo "simulation run passed"
